/* frontend_top.f */
source/bpred_pkg.sv
source/fetch_pkg.sv
source/fetch_id_if.sv
source/branch_predictor.sv
source/fetch_unit.sv
source/core_if_id.sv
source/branch_resolver.sv
source/frontend_top.sv
verif/tb_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_frontend \
    -f frontend_top.f -o tb_frontend; then
  echo "Verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/tb_frontend); then
  printf '%s\n' "$out"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verif/frontend_patterns.hex */
// Columns: address, instruction word, branch outcome bits
// Outcome bit n is the result of the n-th execution of that branch
00000000 00000093 00000000
00000004 00500113 00000000
00000008 00000013 00000000
0000000c 00108093 00000000
00000010 00208863 00000010
00000014 00000013 00000000
00000018 00000013 00000000
0000001c ff1ff06f 00000000
00000020 00118193 00000000
00000024 00000013 00000000
00000028 00118193 00000000
0000002c 00000013 00000000
00000030 00118193 00000000
00000034 00000013 00000000
00000038 00118193 00000000
0000003c 00000013 00000000
00000040 00118193 00000000
00000044 00000013 00000000
00000048 00118193 00000000
0000004c 00000013 00000000

/* verif/tb_frontend.sv */
/*
  Front end testbench: models a credit-based instruction memory,
  replays the pattern program and checks ID order, redirects and stalls
*/
`timescale 1ns/1ps

module tb_frontend;
  localparam int IMEM_CREDITS    = 4;
  localparam int MAX_PAT         = 64;
  localparam int CYCLES_PER_STEP = 40;
  localparam int N_TESTS         = 6;
  localparam int T_RESET = 0;
  localparam int T_ORDER = 1;
  localparam int T_REDIR = 2;
  localparam int T_LEARN = 3;
  localparam int T_CRED  = 4;
  localparam int T_STALL = 5;

  logic        clk, rst;
  logic        imem_req_valid, imem_rsp_valid;
  logic [31:0] imem_req_addr, imem_rsp_data;
  logic        id_stall, br_taken;
  logic        id_valid, redirect_valid;
  logic [31:0] id_pc, id_inst, redirect_pc;

  // Three words per pattern row
  logic [31:0] pat [3*MAX_PAT];
  int          exec_cnt [MAX_PAT];
  int          n_pat, n_steps, cycle, last_due, steps_done;
  int          jal_runs, jal_redirects, failed, held, drop_pend;
  logic [31:0] arch_pc;
  logic        done, seen_req, have_prev;
  logic        prev_stall, prev_redirect, prev_valid;
  logic [31:0] prev_pc, prev_inst;

  // Memory responses waiting to go out, in request order
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];

  string test_name [N_TESTS];
  int    errors [N_TESTS];

  frontend_top #(.IMEM_CREDITS(IMEM_CREDITS)) u_frontend_top (
    .clk(clk), .rst(rst),
    .imem_req_valid(imem_req_valid), .imem_req_addr(imem_req_addr),
    .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
    .id_stall(id_stall), .br_taken(br_taken),
    .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
  );

  always #5 clk = ~clk;

  function automatic int find_row(input logic [31:0] addr);
    for (int i = 0; i < n_pat; i++) begin
      if (pat[3*i] == addr) return i;
    end
    return -1;
  endfunction

  // Outside the program the memory holds address-dependent OP-IMM words
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    int row;
    row = find_row(addr);
    if (row >= 0) return pat[3*row+1];
    return {addr[31:7] ^ addr[24:0], 7'b0010011};
  endfunction

  function automatic logic branch_outcome(input int row);
    return ((pat[3*row+2] >> exec_cnt[row]) & 32'd1) != 32'd0;
  endfunction

  // RV32 next PC for JAL, conditional branches and everything else
  function automatic logic [31:0] arch_next(input logic [31:0] pc, input logic [31:0] w,
                                            input logic taken);
    logic [31:0] imm;
    if (w[6:0] == 7'b1101111) begin
      imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      return pc + imm;
    end
    if (w[6:0] == 7'b1100011 && taken) begin
      imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  task automatic report_mismatch(input int t, input logic [31:0] exp, input logic [31:0] act);
    errors[t]++;
    $display("FAIL %s: expected %h, actual %h", test_name[t], exp, act);
  endtask

  task automatic report_problem(input int t, input string what);
    errors[t]++;
    $display("FAIL %s: %s", test_name[t], what);
  endtask

  // Word leaving ID this cycle
  task automatic check_accept();
    int          row;
    logic [31:0] nxt;
    logic [31:0] word;
    if (id_pc != arch_pc) begin
      report_mismatch(T_ORDER, arch_pc, id_pc);
      arch_pc = id_pc;
    end
    row = find_row(id_pc);
    if (row < 0) begin
      report_problem(T_ORDER, "ID holds a word from outside the program");
      done = 1'b1;
      return;
    end
    word = pat[3*row+1];
    if (id_inst != word) report_mismatch(T_ORDER, word, id_inst);
    nxt = arch_next(id_pc, word, branch_outcome(row));
    if (redirect_valid && redirect_pc != nxt) report_mismatch(T_REDIR, nxt, redirect_pc);
    if (word[6:0] == 7'b1101111) begin
      jal_runs++;
      if (redirect_valid) jal_redirects++;
    end
    exec_cnt[row]++;
    steps_done++;
    arch_pc = nxt;
    if (find_row(arch_pc) < 0) done = 1'b1;
  endtask

  // Sample outputs mid-cycle, where they are settled
  always @(negedge clk) begin
    int due;
    if (rst) begin
      if (imem_req_valid || id_valid || redirect_valid) begin
        report_problem(T_RESET, "control output high during reset");
      end
    end else begin
      if (!have_prev && (id_valid || redirect_valid)) begin
        report_problem(T_RESET, "ID or redirect active right after reset");
      end
      if (imem_req_valid) begin
        if (!seen_req && imem_req_addr != 32'd0) report_mismatch(T_RESET, 32'd0, imem_req_addr);
        seen_req = 1'b1;
        rsp_data_q.push_back(mem_word(imem_req_addr));
        due = cycle + 1 + int'($urandom % 4);
        last_due = (due > last_due) ? due : last_due + 1;
        rsp_due_q.push_back(last_due);
      end
      // Words answered but not yet taken into IF/ID still hold a credit
      if (imem_rsp_valid) begin
        if (drop_pend > 0) drop_pend--;
        else held++;
      end
      if (have_prev && !prev_stall && !prev_redirect && id_valid) held--;
      if (rsp_due_q.size() + held > IMEM_CREDITS) begin
        report_mismatch(T_CRED, 32'(IMEM_CREDITS), 32'(rsp_due_q.size() + held));
      end
      // Redirect empties the queue and dooms the unanswered requests
      if (redirect_valid) begin
        held      = 0;
        drop_pend = rsp_due_q.size();
      end
      if (have_prev && prev_stall && !prev_redirect) begin
        if (id_valid != prev_valid) report_mismatch(T_STALL, 32'(prev_valid), 32'(id_valid));
        if (id_pc != prev_pc) report_mismatch(T_STALL, prev_pc, id_pc);
        if (id_inst != prev_inst) report_mismatch(T_STALL, prev_inst, id_inst);
      end
      if (redirect_valid && !(id_valid && !id_stall)) begin
        report_problem(T_REDIR, "redirect raised without an active ID word");
      end
      if (id_valid && !id_stall && !done) check_accept();
      have_prev     = 1'b1;
      prev_stall    = id_stall;
      prev_redirect = redirect_valid;
      prev_valid    = id_valid;
      prev_pc       = id_pc;
      prev_inst     = id_inst;
    end
  end

  // Inputs change shortly after the rising edge
  always @(posedge clk) begin
    int row;
    #1;
    cycle++;
    id_stall = ($urandom % 4) == 0;
    row = find_row(id_pc);
    br_taken = (row >= 0) ? branch_outcome(row) : 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      imem_rsp_valid = 1'b1;
      imem_rsp_data  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      imem_rsp_valid = 1'b0;
      imem_rsp_data  = 32'd0;
    end
  end

  initial begin
    wait (n_steps > 0);
    repeat (n_steps * CYCLES_PER_STEP) @(posedge clk);
    if (!done) begin
      $display("Watchdog expired after %0d cycles before the program completed",
               n_steps * CYCLES_PER_STEP);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] pc;
    int          row;
    clk = 1'b0;
    rst = 1'b1;
    imem_rsp_valid = 1'b0;
    imem_rsp_data  = 32'd0;
    id_stall = 1'b0;
    br_taken = 1'b0;
    cycle = 0;
    last_due = 0;
    held = 0;
    drop_pend = 0;
    done = 1'b0;
    seen_req = 1'b0;
    have_prev = 1'b0;
    arch_pc = 32'd0;
    test_name[T_RESET] = "reset";
    test_name[T_ORDER] = "program_order";
    test_name[T_REDIR] = "redirect";
    test_name[T_LEARN] = "learning";
    test_name[T_CRED]  = "credits";
    test_name[T_STALL] = "stall";
    void'($urandom(44250));
    for (int i = 0; i < 3*MAX_PAT; i++) pat[i] = 32'hffff_ffff;
    $readmemh("verif/frontend_patterns.hex", pat);
    n_pat = 0;
    while (n_pat < MAX_PAT && pat[3*n_pat] != 32'hffff_ffff) n_pat++;
    // Walk the program once to size the run
    pc = 32'd0;
    row = find_row(pc);
    while (row >= 0 && n_steps < 1000) begin
      pc = arch_next(pc, pat[3*row+1], branch_outcome(row));
      exec_cnt[row]++;
      n_steps++;
      row = find_row(pc);
    end
    for (int i = 0; i < MAX_PAT; i++) exec_cnt[i] = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    if (n_steps == 0) begin
      report_problem(T_ORDER, "pattern file holds no program");
    end else begin
      wait (done);
      repeat (2) @(posedge clk);
      if (jal_redirects != 1) report_mismatch(T_LEARN, 32'd1, 32'(jal_redirects));
      if (jal_runs < 2) report_problem(T_LEARN, "JAL loop ran fewer than two times");
    end
    failed = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      if (errors[t] == 0) begin
        $display("test %s: ok", test_name[t]);
      end else begin
        $display("test %s: %0d errors", test_name[t], errors[t]);
        failed++;
      end
    end
    $display("tests: %0d, passed: %0d, failed: %0d, ID words checked: %0d",
             N_TESTS, N_TESTS - failed, failed, steps_done);
    if (failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* source/frontend_top.sv */
/*
  RV32 instruction fetch front end: fetch, predictor, IF/ID and resolver
*/
`timescale 1ns/1ps

module frontend_top #(
  parameter int IMEM_CREDITS = 4,
  parameter int BTB_ENTRIES  = 8,
  parameter int PHT_ENTRIES  = 8
) (
  input  logic        clk,
  input  logic        rst,
  output logic        imem_req_valid,
  output logic [31:0] imem_req_addr,
  input  logic        imem_rsp_valid,
  input  logic [31:0] imem_rsp_data,
  input  logic        id_stall,
  input  logic        br_taken,
  output logic        id_valid,
  output logic [31:0] id_pc,
  output logic [31:0] id_inst,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc
);
  import bpred_pkg::*;

  fetch_id_if if_bus ();
  fetch_id_if id_bus ();

  logic                 pred_hit, pred_btb_v, if_id_we;
  logic [31:0]          pred_target, fetch_pc;
  logic [PHT_CTR_W-1:0] pred_pht;
  logic [BHR_W-1:0]     pred_bhr;
  btb_type_e            pred_type;

  // Training bundle from ID back to the predictor
  logic                 upd_valid, upd_taken;
  logic [31:0]          upd_pc, upd_target;
  btb_type_e            upd_type;
  logic [PHT_CTR_W-1:0] upd_pht;
  logic [BHR_W-1:0]     upd_bhr;

  fetch_unit #(.IMEM_CREDITS(IMEM_CREDITS)) u_fetch_unit (
    .clk(clk), .rst(rst),
    .imem_req_valid(imem_req_valid), .imem_req_addr(imem_req_addr),
    .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
    .pred_hit(pred_hit), .pred_target(pred_target), .pred_pht(pred_pht),
    .pred_bhr(pred_bhr), .pred_type(pred_type), .pred_btb_v(pred_btb_v),
    .fetch_pc(fetch_pc), .id_stall(id_stall), .if_id_we(if_id_we),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .out(if_bus)
  );

  branch_predictor #(.BTB_ENTRIES(BTB_ENTRIES), .PHT_ENTRIES(PHT_ENTRIES)) u_branch_predictor (
    .clk(clk), .rst(rst), .fetch_pc(fetch_pc),
    .pred_hit(pred_hit), .pred_target(pred_target), .pred_pht(pred_pht),
    .pred_bhr(pred_bhr), .pred_type(pred_type), .pred_btb_v(pred_btb_v),
    .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_target(upd_target),
    .upd_type(upd_type), .upd_taken(upd_taken), .upd_pht(upd_pht), .upd_bhr(upd_bhr)
  );

  // A redirect flushes the word now in ID
  core_if_id u_core_if_id (
    .clk(clk), .rst(rst), .if_id_we(if_id_we), .if_flush(redirect_valid),
    .in(if_bus), .out(id_bus)
  );

  branch_resolver u_branch_resolver (
    .id(id_bus), .id_stall(id_stall), .br_taken(br_taken),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_target(upd_target),
    .upd_type(upd_type), .upd_taken(upd_taken), .upd_pht(upd_pht), .upd_bhr(upd_bhr)
  );

  assign id_valid = id_bus.valid;
  assign id_pc    = id_bus.pc;
  assign id_inst  = id_bus.inst_word;

endmodule

/* source/branch_resolver.sv */
/*
  ID-stage branch resolution for JAL and conditional branches,
  raises redirects on mispredicts and trains the predictor
*/
`timescale 1ns/1ps

module branch_resolver (
  fetch_id_if.consumer                    id,
  input  logic                            id_stall,
  input  logic                            br_taken,
  output logic                            redirect_valid,
  output logic [31:0]                     redirect_pc,
  output logic                            upd_valid,
  output logic [31:0]                     upd_pc,
  output logic [31:0]                     upd_target,
  output bpred_pkg::btb_type_e            upd_type,
  output logic                            upd_taken,
  output logic [bpred_pkg::PHT_CTR_W-1:0] upd_pht,
  output logic [bpred_pkg::BHR_W-1:0]     upd_bhr
);
  import bpred_pkg::*;
  import fetch_pkg::*;

  inst_word_u  iw;
  logic        is_jal, is_br, active;
  logic [31:0] j_imm, b_imm, real_target, real_next, pred_next;

  assign iw     = id.inst_word;
  assign is_jal = (iw.j_view.opcode == OPC_JAL);
  assign is_br  = (iw.b_view.opcode == OPC_BRANCH);

  // Reassemble the scattered immediates
  assign j_imm = {{11{iw.j_view.imm20}}, iw.j_view.imm20, iw.j_view.imm19_12,
                  iw.j_view.imm11, iw.j_view.imm10_1, 1'b0};
  assign b_imm = {{19{iw.b_view.imm12}}, iw.b_view.imm12, iw.b_view.imm11,
                  iw.b_view.imm10_5, iw.b_view.imm4_1, 1'b0};

  assign real_target = id.pc + (is_jal ? j_imm : b_imm);
  assign real_next   = (is_jal || (is_br && br_taken)) ? real_target : id.pc_plus_4;

  // Without a BTB entry fetch went sequential
  assign pred_next = id.btb_v ? id.pred_target : id.pc_plus_4;

  assign active         = id.valid && !id_stall;
  assign redirect_valid = active && (real_next != pred_next);
  assign redirect_pc    = real_next;

  assign upd_valid  = active && (is_jal || is_br);
  assign upd_pc     = id.pc;
  assign upd_target = real_target;
  assign upd_type   = is_jal ? BTB_JUMP : BTB_COND_BRANCH;
  assign upd_taken  = is_jal || br_taken;
  assign upd_pht    = id.delayed_pht;
  assign upd_bhr    = id.delayed_bhr;

endmodule

/* source/core_if_id.sv */
/*
  IF/ID pipeline register: clears on reset or flush, loads on write,
  holds otherwise
*/
`timescale 1ns/1ps

module core_if_id (
  input  logic         clk,
  input  logic         rst,
  input  logic         if_id_we,
  input  logic         if_flush,
  fetch_id_if.consumer in,
  fetch_id_if.producer out
);
  import bpred_pkg::*;

  // Flush beats write
  always_ff @(posedge clk) begin
    if (rst || if_flush) begin
      out.valid       <= 1'b0;
      out.pc          <= '0;
      out.pc_plus_4   <= '0;
      out.inst_word   <= '0;
      out.pred_target <= '0;
      out.delayed_pht <= '0;
      out.delayed_bhr <= '0;
      out.btb_type    <= BTB_NONE;
      out.btb_v       <= 1'b0;
    end else if (if_id_we) begin
      out.valid       <= in.valid;
      out.pc          <= in.pc;
      out.pc_plus_4   <= in.pc_plus_4;
      out.inst_word   <= in.inst_word;
      out.pred_target <= in.pred_target;
      out.delayed_pht <= in.delayed_pht;
      out.delayed_bhr <= in.delayed_bhr;
      out.btb_type    <= in.btb_type;
      out.btb_v       <= in.btb_v;
    end
  end

endmodule

/* source/fetch_unit.sv */
/*
  Fetch PC, credit-based instruction memory requests and in-order
  pairing of returned words with their prediction snapshots
*/
`timescale 1ns/1ps

module fetch_unit #(
  parameter int IMEM_CREDITS = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  output logic                            imem_req_valid,
  output logic [31:0]                     imem_req_addr,
  input  logic                            imem_rsp_valid,
  input  logic [31:0]                     imem_rsp_data,
  input  logic                            pred_hit,
  input  logic [31:0]                     pred_target,
  input  logic [bpred_pkg::PHT_CTR_W-1:0] pred_pht,
  input  logic [bpred_pkg::BHR_W-1:0]     pred_bhr,
  input  bpred_pkg::btb_type_e            pred_type,
  input  logic                            pred_btb_v,
  output logic [31:0]                     fetch_pc,
  input  logic                            id_stall,
  output logic                            if_id_we,
  input  logic                            redirect_valid,
  input  logic [31:0]                     redirect_pc,
  fetch_id_if.producer                    out
);
  import bpred_pkg::*;

  localparam int PTR_W = (IMEM_CREDITS > 1) ? $clog2(IMEM_CREDITS) : 1;
  localparam int CNT_W = $clog2(IMEM_CREDITS + 1);

  // Snapshot queue, one slot per outstanding credit
  logic [31:0]          q_pc   [IMEM_CREDITS];
  logic [31:0]          q_next [IMEM_CREDITS];
  logic [31:0]          q_word [IMEM_CREDITS];
  logic [PHT_CTR_W-1:0] q_pht  [IMEM_CREDITS];
  logic [BHR_W-1:0]     q_bhr  [IMEM_CREDITS];
  btb_type_e            q_type [IMEM_CREDITS];
  logic                 q_btb_v[IMEM_CREDITS];

  logic [PTR_W-1:0] wr_ptr, fill_ptr, rd_ptr;
  logic [CNT_W-1:0] credits, live, ready, drop_cnt, drop_nxt;
  logic [31:0]      pc, next_pc;
  logic             run, rsp_keep, rsp_drop, pop;

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(IMEM_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign next_pc        = pred_hit ? pred_target : pc + 32'd4;
  assign fetch_pc       = pc;
  assign imem_req_addr  = pc;
  assign imem_req_valid = run && (credits != '0) && !redirect_valid;

  // Responses owed to a flushed path are thrown away
  assign rsp_drop = imem_rsp_valid && (drop_cnt != '0);
  assign rsp_keep = imem_rsp_valid && (drop_cnt == '0);
  assign drop_nxt = drop_cnt + live - CNT_W'(imem_rsp_valid);

  // IF/ID loads a bubble whenever ID moves on and the queue is empty
  assign if_id_we = !id_stall && !redirect_valid;
  assign pop      = (ready != '0) && if_id_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      run      <= 1'b0;
      pc       <= '0;
      credits  <= CNT_W'(IMEM_CREDITS);
      live     <= '0;
      ready    <= '0;
      drop_cnt <= '0;
      wr_ptr   <= '0;
      fill_ptr <= '0;
      rd_ptr   <= '0;
    end else if (redirect_valid) begin
      pc       <= redirect_pc;
      live     <= '0;
      ready    <= '0;
      drop_cnt <= drop_nxt;
      credits  <= CNT_W'(IMEM_CREDITS) - drop_nxt;
      wr_ptr   <= '0;
      fill_ptr <= '0;
      rd_ptr   <= '0;
    end else begin
      run <= 1'b1;
      if (imem_req_valid) begin
        pc     <= next_pc;
        wr_ptr <= bump(wr_ptr);
      end
      if (rsp_keep) begin
        fill_ptr <= bump(fill_ptr);
      end
      if (rsp_drop) begin
        drop_cnt <= drop_cnt - 1'b1;
      end
      if (pop) begin
        rd_ptr <= bump(rd_ptr);
      end
      live    <= live + CNT_W'(imem_req_valid) - CNT_W'(rsp_keep);
      ready   <= ready + CNT_W'(rsp_keep) - CNT_W'(pop);
      credits <= credits - CNT_W'(imem_req_valid) + CNT_W'(pop) + CNT_W'(rsp_drop);
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req_valid) begin
      q_pc[wr_ptr]    <= pc;
      q_next[wr_ptr]  <= next_pc;
      q_pht[wr_ptr]   <= pred_pht;
      q_bhr[wr_ptr]   <= pred_bhr;
      q_type[wr_ptr]  <= pred_type;
      q_btb_v[wr_ptr] <= pred_btb_v;
    end
    if (rsp_keep) begin
      q_word[fill_ptr] <= imem_rsp_data;
    end
  end

  // Queue head toward IF/ID
  assign out.valid       = (ready != '0);
  assign out.pc          = q_pc[rd_ptr];
  assign out.pc_plus_4   = q_pc[rd_ptr] + 32'd4;
  assign out.inst_word   = q_word[rd_ptr];
  assign out.pred_target = q_next[rd_ptr];
  assign out.delayed_pht = q_pht[rd_ptr];
  assign out.delayed_bhr = q_bhr[rd_ptr];
  assign out.btb_type    = q_type[rd_ptr];
  assign out.btb_v       = q_btb_v[rd_ptr];

endmodule

/* source/branch_predictor.sv */
/*
  Direct-mapped BTB plus gshare PHT, looked up on the fetch PC
  and trained from branches resolved in ID
*/
`timescale 1ns/1ps

module branch_predictor #(
  parameter int BTB_ENTRIES = 8,
  parameter int PHT_ENTRIES = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [31:0]                     fetch_pc,
  output logic                            pred_hit,
  output logic [31:0]                     pred_target,
  output logic [bpred_pkg::PHT_CTR_W-1:0] pred_pht,
  output logic [bpred_pkg::BHR_W-1:0]     pred_bhr,
  output bpred_pkg::btb_type_e            pred_type,
  output logic                            pred_btb_v,
  input  logic                            upd_valid,
  input  logic [31:0]                     upd_pc,
  input  logic [31:0]                     upd_target,
  input  bpred_pkg::btb_type_e            upd_type,
  input  logic                            upd_taken,
  input  logic [bpred_pkg::PHT_CTR_W-1:0] upd_pht,
  input  logic [bpred_pkg::BHR_W-1:0]     upd_bhr
);
  import bpred_pkg::*;

  localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
  localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);
  localparam int TAG_W     = 30 - BTB_IDX_W;

  logic                 btb_valid  [BTB_ENTRIES];
  logic [TAG_W-1:0]     btb_tag    [BTB_ENTRIES];
  logic [31:0]          btb_target [BTB_ENTRIES];
  btb_type_e            btb_kind   [BTB_ENTRIES];
  logic [PHT_CTR_W-1:0] pht        [PHT_ENTRIES];
  logic [BHR_W-1:0]     bhr;

  logic [BTB_IDX_W-1:0] rd_btb_idx, wr_btb_idx;
  logic [PHT_IDX_W-1:0] rd_pht_idx, wr_pht_idx;
  logic [PHT_CTR_W-1:0] ctr_next;

  // Lookup side
  assign rd_btb_idx = fetch_pc[2 +: BTB_IDX_W];
  assign rd_pht_idx = fetch_pc[2 +: PHT_IDX_W] ^ PHT_IDX_W'(bhr);

  assign pred_btb_v  = btb_valid[rd_btb_idx] &&
                       (btb_tag[rd_btb_idx] == fetch_pc[31:2+BTB_IDX_W]);
  assign pred_type   = pred_btb_v ? btb_kind[rd_btb_idx] : BTB_NONE;
  assign pred_target = btb_target[rd_btb_idx];
  assign pred_pht    = pht[rd_pht_idx];
  assign pred_bhr    = bhr;
  assign pred_hit    = pred_btb_v && ((pred_type == BTB_JUMP) ||
                       ((pred_type == BTB_COND_BRANCH) && pred_pht[PHT_CTR_W-1]));

  // Training side uses the history captured at fetch time
  assign wr_btb_idx = upd_pc[2 +: BTB_IDX_W];
  assign wr_pht_idx = upd_pc[2 +: PHT_IDX_W] ^ PHT_IDX_W'(upd_bhr);

  always_comb begin
    ctr_next = upd_pht;
    if (upd_taken && upd_pht != CTR_MAX) begin
      ctr_next = upd_pht + 1'b1;
    end else if (!upd_taken && upd_pht != CTR_MIN) begin
      ctr_next = upd_pht - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bhr <= '0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid[i] <= 1'b0;
      end
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht[i] <= WEAK_TAKEN;
      end
    end else if (upd_valid) begin
      bhr <= {bhr[BHR_W-2:0], upd_taken};
      if (upd_taken) begin
        btb_valid[wr_btb_idx] <= 1'b1;
      end
      // Jumps are always taken, counter stays untouched
      if (upd_type == BTB_COND_BRANCH) begin
        pht[wr_pht_idx] <= ctr_next;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (upd_valid && upd_taken) begin
      btb_tag[wr_btb_idx]    <= upd_pc[31:2+BTB_IDX_W];
      btb_target[wr_btb_idx] <= upd_target;
      btb_kind[wr_btb_idx]   <= upd_type;
    end
  end

endmodule

/* source/fetch_id_if.sv */
/*
  Fetched word plus its prediction snapshot, one stage hop
*/
`timescale 1ns/1ps

interface fetch_id_if;
  import bpred_pkg::*;

  logic                 valid;
  logic [31:0]          pc;
  logic [31:0]          pc_plus_4;
  logic [31:0]          inst_word;
  // Next fetch PC chosen when this word was requested
  logic [31:0]          pred_target;
  logic [PHT_CTR_W-1:0] delayed_pht;
  logic [BHR_W-1:0]     delayed_bhr;
  btb_type_e            btb_type;
  logic                 btb_v;

  modport producer (output valid, pc, pc_plus_4, inst_word, pred_target,
                    delayed_pht, delayed_bhr, btb_type, btb_v);
  modport consumer (input valid, pc, pc_plus_4, inst_word, pred_target,
                    delayed_pht, delayed_bhr, btb_type, btb_v);

endinterface

/* source/fetch_pkg.sv */
/*
  Fetch definitions: RV32 instruction word with branch and jump views,
  and the opcodes the front end decodes
*/
package fetch_pkg;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Same 32 bits, read as B-type or J-type
  typedef union packed {
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_view;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_view;
  } inst_word_u;

endpackage

/* source/bpred_pkg.sv */
/*
  Branch predictor definitions: history and counter widths,
  BTB entry type and saturating counter constants
*/
package bpred_pkg;

  // Global history length, fixed
  localparam int BHR_W = 3;

  // PHT counter width
  localparam int PHT_CTR_W = 2;

  // Kind of control transfer held in a BTB entry
  typedef enum logic [1:0] {
    BTB_NONE        = 2'b00,
    BTB_COND_BRANCH = 2'b01,
    BTB_JUMP        = 2'b10
  } btb_type_e;

  // Counter reset value
  localparam logic [PHT_CTR_W-1:0] WEAK_TAKEN = 2'b10;

  // Saturation limits
  localparam logic [PHT_CTR_W-1:0] CTR_MAX = '1;
  localparam logic [PHT_CTR_W-1:0] CTR_MIN = '0;

endpackage
